// File: sim/boardCases.txt
# op port data sel expected, all but port in hex
# W write, R read, B set notButton, L notLed, D display (four segment bytes, digit 0 first)
R 0 00000000 F 00000000
R 4 00000000 F 00000000
R 5 00000000 F 00000000
R 7 00000000 F 00000000
L 0 00000000 0 0000000F
W 0 12345678 F 00000000
W 1 9ABCDEF0 F 00000000
W 2 DEADBEEF F 00000000
W 6 A5A55A5A F 00000000
W 7 FFFFFFFF F 00000000
R 0 00000000 F 12345678
R 1 00000000 F 9ABCDEF0
R 6 00000000 F A5A55A5A
W 2 11223344 5 00000000
R 2 00000000 F DE22BE44
W 7 00AB0000 4 00000000
R 7 00000000 F FFABFFFF
B 0 0000000A 0 00000000
R 4 00000000 F 00000005
W 4 000000AF F 00000000
R 4 00000000 F 000000A5
L 0 00000000 0 00000005
B 0 0000000F 0 00000000
W 4 00000030 1 00000000
R 4 00000000 F 00000030
L 0 00000000 0 0000000C
W 5 0000A1F6 F 00000000
D 5 0000A1F6 0 88F98E82
W 5 00003C90 3 00000000
D 5 00003C90 0 B0C690C0

// File: compile.f
verilog/boardPkg.sv
verilog/buttonSync.sv
verilog/mmioPorts.sv
verilog/sevenSegMux.sv
verilog/boardTop.sv
sim/boardTopTb.sv

// File: Makefile
# Verilator simulation of the board harness
VERILATOR ?= verilator
TOP ?= boardTopTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: simulate clean

# Pass only if the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/boardTopTb.sv
//--------------------------------------
// Board harness testbench
// Replays file cases on bus and board I/O
//--------------------------------------
`default_nettype none

module boardTopTb
	import boardPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// Short scan so each digit lasts four clocks
	localparam int tbScanDivide = 4;

	logic clock = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [portWidth/8-1:0] sel;
	logic [portWidth-1:0] datWrite;
	logic [portWidth-1:0] datRead;
	logic ack;
	logic [3:0] notButton;
	logic [3:0] notLed;
	logic [7:0] segment;
	logic [3:0] digit;

	// Cases as read from the file
	byte caseOp [$];
	int casePort [$];
	logic [portWidth-1:0] caseData [$];
	logic [3:0] caseSel [$];
	logic [portWidth-1:0] caseExpect [$];
	bit casesLoaded = 1'b0;

	// Expected port contents, merged lane by lane
	logic [portWidth-1:0] shadow [portCount];
	// Buttons as the synchronizer should report them
	logic [3:0] pressed;

	int wordErrors = 0;
	int ledErrors = 0;
	int segmentErrors = 0;
	int otherErrors = 0;

	boardTop #(.scanDivide(tbScanDivide)) DUT
	(
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.sel(sel),
		.datWrite(datWrite),
		.datRead(datRead),
		.ack(ack),
		.notButton(notButton),
		.notLed(notLed),
		.segment(segment),
		.digit(digit)
	);

	// 40 ns period
	always #20 clock = ~clock;

	task automatic checkWord(input logic [portWidth-1:0] actual,
		input logic [portWidth-1:0] expected, input string what);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("ERR %0t %s read %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkLeds(input logic [3:0] actual, input logic [3:0] expected);
		if (actual !== expected)
		begin
			ledErrors++;
			$display("ERR %0t notLed is %b, expected %b", $time, actual, expected);
		end
	endtask

	task automatic checkSegment(input logic [7:0] actual, input logic [7:0] expected,
		input int position);
		if (actual !== expected)
		begin
			segmentErrors++;
			$display("ERR %0t digit %0d segment %h, expected %h", $time, position,
				actual, expected);
		end
	endtask

	// One Wishbone classic cycle, ack expected one edge after the drive
	task automatic busCycle(input logic write, input int port,
		input logic [portWidth-1:0] wordIn, input logic [3:0] lanes,
		output logic [portWidth-1:0] wordOut);
		int waited;
		waited = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = port[2:0];
		sel = lanes;
		datWrite = wordIn;
		while (ack !== 1'b1 && waited < 8)
		begin
			@(posedge clock);
			#2;
			waited++;
		end
		wordOut = datRead;
		if (ack !== 1'b1)
		begin
			otherErrors++;
			$display("Bus hung: port %0d gave no ack within 8 cycles", port);
		end
		else if (waited != 1)
		begin
			otherErrors++;
			$display("ERR %0t ack after %0d cycles on port %0d", $time, waited + 1, port);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(posedge clock);
		#2;
		// Ack lasts one cycle only
		if (ack !== 1'b0)
		begin
			otherErrors++;
			$display("ERR %0t ack held a second cycle on port %0d", $time, port);
		end
	endtask

	// One clock step of the display watch, one digit low at every sample
	task automatic nextSample(inout int waited);
		@(posedge clock);
		#2;
		waited++;
		if ($countones(~digit) != 1)
		begin
			otherErrors++;
			$display("ERR %0t digit lines %b, expected exactly one low", $time, digit);
		end
	endtask

	// Patterns packed four bytes wide, digit 0 in the top byte
	task automatic checkDisplay(input logic [portWidth-1:0] patterns);
		int waited;
		int limit;
		waited = 0;
		limit = 24 * tbScanDivide;
		// Skip a digit 0 still showing from before the write
		while (digit[0] === 1'b0 && waited < limit)
			nextSample(waited);
		for (int position = 0; position < 4; position++)
		begin
			while (digit[position] !== 1'b0 && waited < limit)
				nextSample(waited);
			if (digit[position] !== 1'b0)
			begin
				otherErrors++;
				$display("Display scan stalled waiting for digit %0d", position);
				break;
			end
			checkSegment(segment, patterns[31 - 8*position -: 8], position);
		end
	endtask

	initial
	begin
		int fd;
		int port;
		int fields;
		string line;
		byte op;
		logic [2:0] slot;
		logic [3:0] lanes;
		logic [portWidth-1:0] data;
		logic [portWidth-1:0] expected;
		logic [portWidth-1:0] readBack;
		logic [portWidth-1:0] merged;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 3'd0;
		sel = 4'h0;
		datWrite = '0;
		notButton = 4'hF;
		pressed = 4'h0;
		for (int i = 0; i < portCount; i++)
			shadow[i] = '0;

		fd = $fopen("sim/boardCases.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("Could not open the cases file sim/boardCases.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				// Blank lines and # comments carry no case
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					fields = $sscanf(line, "%c %d %h %h %h", op, port, data, lanes, expected);
					if (fields == 5)
					begin
						caseOp.push_back(op);
						casePort.push_back(port);
						caseData.push_back(data);
						caseSel.push_back(lanes);
						caseExpect.push_back(expected);
					end
					else
					begin
						otherErrors++;
						$display("Malformed case line: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		casesLoaded = 1'b1;

		// Two reset cycles, then inputs move 2 ns past each edge
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		if (ack !== 1'b0)
		begin
			otherErrors++;
			$display("ERR %0t ack high after reset", $time);
		end

		for (int index = 0; index < caseOp.size(); index++)
		begin
			op = caseOp[index];
			port = casePort[index];
			slot = port[2:0];
			data = caseData[index];
			lanes = caseSel[index];
			expected = caseExpect[index];
			case (op)
				"W":
				begin
					busCycle(1'b1, port, data, lanes, readBack);
					for (int lane = 0; lane < 4; lane++)
						if (lanes[lane])
							shadow[slot][lane*8 +: 8] = data[lane*8 +: 8];
				end
				"R":
				begin
					busCycle(1'b0, port, data, lanes, readBack);
					merged = shadow[slot];
					// Port 4 low nibble reads the live buttons
					if (slot == 3'd4)
						merged[3:0] = pressed;
					checkWord(readBack, expected, $sformatf("port %0d", port));
					checkWord(readBack, merged, $sformatf("port %0d merged", port));
				end
				"B":
				begin
					notButton = data[3:0];
					pressed = ~data[3:0];
					repeat (3) @(posedge clock);
					#2;
				end
				"L":
					checkLeds(notLed, expected[3:0]);
				"D":
					checkDisplay(expected);
				default:
				begin
					otherErrors++;
					$display("Unknown operation in case %0d", index);
				end
			endcase
		end

		$display("Errors: word %0d, led %0d, segment %0d, other %0d",
			wordErrors, ledErrors, segmentErrors, otherErrors);
		if (wordErrors + ledErrors + segmentErrors + otherErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Budget of 40 cycles per case plus margin
	initial
	begin
		wait (casesLoaded);
		repeat (caseOp.size() * 40 + 100) @(posedge clock);
		$display("Watchdog expired: the cases did not finish in their cycle budget");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/boardTop.sv
//--------------------------------------
// Development board harness top level
// Bus ports, buttons, LEDs and display
//--------------------------------------
`default_nettype none

module boardTop
	import boardPkg::*;
#(
	parameter int scanDivide = boardPkg::scanDivide
)
(
	input logic clock,
	input logic reset,
	// Wishbone classic slave port, the core is the master
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input logic [portWidth/8-1:0] sel,
	input logic [portWidth-1:0] datWrite,
	output logic [portWidth-1:0] datRead,
	output logic ack,
	// Board I/O, all active low
	input logic [3:0] notButton,
	output logic [3:0] notLed,
	output logic [7:0] segment,
	output logic [3:0] digit
);
	// Synchronized buttons, pressed is high
	logic [3:0] button;
	// LED bits of port 4, lit is high
	logic [3:0] ledState;
	// Low half of port 5
	logic [15:0] displayValue;

	buttonSync buttonSyncInst
	(
		.clock(clock),
		.reset(reset),
		.notButton(notButton),
		.button(button)
	);

	mmioPorts mmioPortsInst
	(
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(portAddr'(adr)),
		.sel(sel),
		.datWrite(datWrite),
		.datRead(datRead),
		.ack(ack),
		.button(button),
		.ledState(ledState),
		.displayValue(displayValue)
	);

	sevenSegMux #(.scanDivide(scanDivide)) sevenSegMuxInst
	(
		.clock(clock),
		.reset(reset),
		.displayValue(displayValue),
		.segment(segment),
		.digit(digit)
	);

	// Board LEDs light on a low line
	assign notLed = ~ledState;

endmodule

`default_nettype wire

// File: verilog/sevenSegMux.sv
//--------------------------------------
// Four-digit seven-segment scanner
// Prescaled scan onto active-low outputs
//--------------------------------------
`default_nettype none

module sevenSegMux
	import boardPkg::*;
#(
	parameter int scanDivide = boardPkg::scanDivide
)
(
	input logic clock,
	input logic reset,
	// Four hex digits with the leftmost in bits 15:12
	input logic [15:0] displayValue,
	output logic [7:0] segment,
	output logic [3:0] digit
);
	localparam int countWidth = $clog2(scanDivide);

	// Clocks spent on the current digit
	logic [countWidth-1:0] prescale;
	// One cycle per digit period
	logic tick;
	// Digit on show
	logic [1:0] index;
	logic [1:0] nextIndex;
	// Nibble for the digit about to be shown
	logic [3:0] nextNibble;

	assign tick = (prescale == countWidth'(scanDivide - 1));
	// Wraps from 3 back to 0
	assign nextIndex = index + 2'd1;

	// Digit 0 is the leftmost position
	always_comb
	begin
		case (nextIndex)
			2'd0: nextNibble = displayValue[15:12];
			2'd1: nextNibble = displayValue[11:8];
			2'd2: nextNibble = displayValue[7:4];
			default: nextNibble = displayValue[3:0];
		endcase
	end

	// Prescaler restarts on each tick
	always_ff @(posedge clock)
	begin
		if (reset || tick)
			prescale <= '0;
		else
			prescale <= prescale + countWidth'(1);
	end

	// Segment and digit lines switch on the same edge
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			index <= 2'd0;
			digit <= 4'b1110;
			segment <= segmentPattern(4'h0);
		end
		else if (tick)
		begin
			index <= nextIndex;
			// Ground only the selected digit
			digit <= ~(4'b0001 << nextIndex);
			segment <= segmentPattern(nextNibble);
		end
	end

	// Exactly one digit grounded at any time
	oneDigitLow: assert property (@(posedge clock) disable iff (reset)
		$onehot(~digit));

endmodule

`default_nettype wire

// File: verilog/mmioPorts.sv
//--------------------------------------
// Memory-mapped port block
// Wishbone classic slave, eight ports
//--------------------------------------
`default_nettype none

module mmioPorts
	import boardPkg::*;
(
	input logic clock,
	input logic reset,
	// Wishbone classic slave side
	input logic cyc,
	input logic stb,
	input logic we,
	input portAddr adr,
	input logic [portWidth/8-1:0] sel,
	input logic [portWidth-1:0] datWrite,
	output logic [portWidth-1:0] datRead,
	output logic ack,
	// Board side
	input logic [3:0] button,
	output logic [3:0] ledState,
	output logic [15:0] displayValue
);
	// Port registers
	logic [portWidth-1:0] ports [portCount];
	// New request, not yet acknowledged
	logic request;
	// Word returned for the addressed port
	logic [portWidth-1:0] readWord;

	// Ack already high means this request was answered
	assign request = cyc && stb && !ack;

	always_comb
	begin
		readWord = ports[adr];
		// Live buttons replace the stored low nibble of port 4
		if (adr == portButtonLed)
			readWord[3:0] = button;
	end

	// Single-cycle registered ack
	always_ff @(posedge clock)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= request;
	end

	// Read data captured alongside ack
	always_ff @(posedge clock)
	begin
		if (request)
			datRead <= readWord;
	end

	// Byte-lane writes at the acknowledging edge
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < portCount; i++)
				ports[i] <= '0;
		end
		else if (request && we)
		begin
			for (int lane = 0; lane < portWidth/8; lane++)
			begin
				if (sel[lane])
					ports[adr][lane*8 +: 8] <= datWrite[lane*8 +: 8];
			end
		end
	end

	// LED bits also feed back through port 4 reads
	assign ledState = ports[portButtonLed][7:4];
	assign displayValue = ports[portDisplay][15:0];

	// Ack only answers a request seen the cycle before
	ackFollowsRequest: assert property (@(posedge clock) disable iff (reset)
		ack |-> $past(cyc && stb));

	// One ack per request
	ackSingleCycle: assert property (@(posedge clock) disable iff (reset)
		ack |=> !ack);

endmodule

`default_nettype wire

// File: verilog/buttonSync.sv
//--------------------------------------
// Push button synchronizer
// Inverts buttons, two flop stages
//--------------------------------------
`default_nettype none

module buttonSync
(
	input logic clock,
	input logic reset,
	// Raw board buttons, pressed is low
	input logic [3:0] notButton,
	// Synchronized, pressed is high
	output logic [3:0] button
);
	// First stage may go metastable
	logic [3:0] stageOne;
	// Second stage settles it
	logic [3:0] stageTwo;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stageOne <= '0;
			stageTwo <= '0;
		end
		else
		begin
			// Inversion ahead of the first flop
			stageOne <= ~notButton;
			stageTwo <= stageOne;
		end
	end

	// No debouncing here, software handles bounce
	assign button = stageTwo;

endmodule

`default_nettype wire

// File: verilog/boardPkg.sv
//--------------------------------------
// Board harness definitions
// Port map, bus widths, display decode
//--------------------------------------
`default_nettype none

package boardPkg;

	// Bus and port register width
	localparam int portWidth = 32;
	// Number of memory-mapped ports
	localparam int portCount = 8;
	// Board clocks per displayed digit
	localparam int scanDivide = 50000;

	// Word addresses of the eight ports
	typedef enum logic [2:0]
	{
		portGeneral0 = 3'd0,
		portGeneral1 = 3'd1,
		portGeneral2 = 3'd2,
		portGeneral3 = 3'd3,
		portButtonLed = 3'd4,
		portDisplay = 3'd5,
		portGeneral6 = 3'd6,
		portGeneral7 = 3'd7
	} portAddr;

	// Hex digit to active-low segments
	// Bit 7 is the decimal point, kept dark; bits 6:0 are g down to a
	function automatic logic [7:0] segmentPattern(input logic [3:0] value);
		case (value)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

endpackage

`default_nettype wire
